// ==== design/rv32i_settings.svh ====
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// Data memory word-address width
// Depth is 2**DMEM_ADDR_BITS words
`define DMEM_ADDR_BITS 8

// Default branch of a select case
// Reports the instance and time of the illegal select
`define BAD_MUX_SEL $error("%m: illegal mux select at %0t", $time)

`endif

// ==== design/rv32i_types_pkg.sv ====
`default_nettype none

package rv32i_types_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;
    typedef logic [3:0]  byte_en_t;

    // Low bits follow funct3
    // Bit 3 selects sub and sra
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_ops_t;

    // Branch funct3, the spare code 010 is used for jumps
    typedef enum logic [2:0] {
        cmp_beq    = 3'b000,
        cmp_bne    = 3'b001,
        cmp_always = 3'b010,
        cmp_blt    = 3'b100,
        cmp_bge    = 3'b101,
        cmp_bltu   = 3'b110,
        cmp_bgeu   = 3'b111
    } cmp_ops_t;

    typedef enum logic [1:0] {
        mem_byte = 2'b00,
        mem_half = 2'b01,
        mem_word = 2'b10
    } mem_width_t;

endpackage

`default_nettype wire

// ==== design/datapath_mux_pkg.sv ====
`default_nettype none

package datapath_mux_pkg;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic {
        alumux2_imm = 1'b0,
        alumux2_rs2 = 1'b1
    } alumux2_sel_t;

    typedef enum logic [3:0] {
        rf_alu_out  = 4'd0,
        rf_br_en    = 4'd1,
        rf_u_imm    = 4'd2,
        rf_lw       = 4'd3,
        rf_pc_plus4 = 4'd4,
        rf_lb       = 4'd5,
        rf_lbu      = 4'd6,
        rf_lh       = 4'd7,
        rf_lhu      = 4'd8
    } regfilemux_sel_t;

    // alu_mod2 drops bit 0 of the target for jalr
    typedef enum logic [1:0] {
        pcmux_pc_plus4 = 2'b00,
        pcmux_alu_out  = 2'b01,
        pcmux_alu_mod2 = 2'b10
    } pcmux_sel_t;

endpackage

`default_nettype wire

// ==== design/execute.sv ====
`default_nettype none

`include "rv32i_settings.svh"

module execute
    import rv32i_types_pkg::*;
    import datapath_mux_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  rv32i_word       pc,
    input  rv32i_word       rs1_data,
    input  rv32i_word       rs2_data,
    input  rv32i_word       imm,
    input  alu_ops_t        alu_op,
    input  cmp_ops_t        cmp_op,
    input  alumux1_sel_t    alumux1_sel,
    input  alumux2_sel_t    alumux2_sel,
    input  pcmux_sel_t      pcmux_sel_in,
    input  regfilemux_sel_t regfilemux_sel,
    input  logic            load_regfile_in,
    input  logic            mem_read,
    input  logic            mem_write,
    input  mem_width_t      mem_width,
    input  rv32i_reg        rd_in_idx,

    output rv32i_word       ex_pc_plus4,
    output rv32i_word       ex_alu_out,
    output rv32i_word       ex_br_en,
    output rv32i_word       ex_store_data,
    output rv32i_word       ex_imm,
    output pcmux_sel_t      ex_pcmux_sel,
    output regfilemux_sel_t ex_regfilemux_sel,
    output logic            ex_load_regfile,
    output logic            ex_mem_read,
    output logic            ex_mem_write,
    output mem_width_t      ex_mem_width,
    output rv32i_reg        ex_rd
);

    rv32i_word alu_a;
    rv32i_word alu_b;
    rv32i_word alu_result;
    logic      cmp_true;

    assign alu_a = (alumux1_sel == alumux1_pc) ? pc : rs1_data;
    assign alu_b = (alumux2_sel == alumux2_rs2) ? rs2_data : imm;

    always_comb
    begin
        alu_result = alu_a + alu_b;
        unique case (alu_op)
            alu_add: alu_result = alu_a + alu_b;
            alu_sub: alu_result = alu_a - alu_b;
            alu_sll: alu_result = alu_a << alu_b[4:0];
            alu_srl: alu_result = alu_a >> alu_b[4:0];
            alu_sra: alu_result = rv32i_word'($signed(alu_a) >>> alu_b[4:0]);
            alu_xor: alu_result = alu_a ^ alu_b;
            alu_or:  alu_result = alu_a | alu_b;
            alu_and: alu_result = alu_a & alu_b;
            default: `BAD_MUX_SEL;
        endcase
    end

    // Branch and slt compares always look at the two register operands
    always_comb
    begin
        cmp_true = 1'b0;
        unique case (cmp_op)
            cmp_beq:    cmp_true = (rs1_data == rs2_data);
            cmp_bne:    cmp_true = (rs1_data != rs2_data);
            cmp_blt:    cmp_true = ($signed(rs1_data) < $signed(rs2_data));
            cmp_bge:    cmp_true = ($signed(rs1_data) >= $signed(rs2_data));
            cmp_bltu:   cmp_true = (rs1_data < rs2_data);
            cmp_bgeu:   cmp_true = (rs1_data >= rs2_data);
            cmp_always: cmp_true = 1'b1;
            default:    `BAD_MUX_SEL;
        endcase
    end

    // EX/MEM control, cleared to a bubble
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ex_br_en          <= '0;
            ex_pcmux_sel      <= pcmux_pc_plus4;
            ex_regfilemux_sel <= rf_alu_out;
            ex_load_regfile   <= 1'b0;
            ex_mem_read       <= 1'b0;
            ex_mem_write      <= 1'b0;
            ex_mem_width      <= mem_word;
            ex_rd             <= '0;
        end
        else
        begin
            ex_br_en          <= {{31{1'b0}}, cmp_true};
            ex_pcmux_sel      <= pcmux_sel_in;
            ex_regfilemux_sel <= regfilemux_sel;
            ex_load_regfile   <= load_regfile_in;
            ex_mem_read       <= mem_read;
            ex_mem_write      <= mem_write;
            ex_mem_width      <= mem_width;
            ex_rd             <= rd_in_idx;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk)
    begin
        ex_pc_plus4   <= pc + 32'd4;
        ex_alu_out    <= alu_result;
        ex_store_data <= rs2_data;
        ex_imm        <= imm;
    end

    // Decode never issues a load and a store together
    assert property (@(posedge clk) disable iff (!rst_n) !(mem_read && mem_write))
        else $error("execute: mem_read and mem_write both set");

endmodule

`default_nettype wire

// ==== design/mem_access.sv ====
`default_nettype none

`include "rv32i_settings.svh"

module mem_access
    import rv32i_types_pkg::*;
    import datapath_mux_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  rv32i_word       ex_pc_plus4,
    input  rv32i_word       ex_alu_out,
    input  rv32i_word       ex_br_en,
    input  rv32i_word       ex_store_data,
    input  rv32i_word       ex_imm,
    input  pcmux_sel_t      ex_pcmux_sel,
    input  regfilemux_sel_t ex_regfilemux_sel,
    input  logic            ex_load_regfile,
    input  logic            ex_mem_read,
    input  logic            ex_mem_write,
    input  mem_width_t      ex_mem_width,
    input  rv32i_reg        ex_rd,

    output rv32i_word       wb_pc_plus4,
    output rv32i_word       wb_alu_out,
    output rv32i_word       wb_br_en,
    output rv32i_word       wb_imm,
    output rv32i_word       wb_r_data,
    output byte_en_t        wb_mem_byte_enable,
    output pcmux_sel_t      wb_pcmux_sel,
    output regfilemux_sel_t wb_regfilemux_sel,
    output logic            wb_load_regfile,
    output rv32i_reg        wb_rd
);

    localparam int ADDR_BITS = `DMEM_ADDR_BITS;

    mem_width_t           access_width;
    byte_en_t             byte_enable;
    rv32i_word            store_lanes;
    logic [ADDR_BITS-1:0] word_addr;
    rv32i_word            dmem [2**ADDR_BITS];

    assign word_addr   = ex_alu_out[ADDR_BITS+1:2];
    assign store_lanes = ex_store_data << {ex_alu_out[1:0], 3'b000};

    // Loads carry their width in the write-back select
    always_comb
    begin
        access_width = mem_word;
        if (ex_mem_write)
            access_width = ex_mem_width;
        else
        begin
            case (ex_regfilemux_sel)
                rf_lb, rf_lbu: access_width = mem_byte;
                rf_lh, rf_lhu: access_width = mem_half;
                default:       access_width = mem_word;
            endcase
        end
    end

    always_comb
    begin
        byte_enable = 4'b1111;
        unique case (access_width)
            mem_byte: byte_enable = 4'b0001 << ex_alu_out[1:0];
            mem_half: byte_enable = 4'b0011 << {ex_alu_out[1], 1'b0};
            mem_word: byte_enable = 4'b1111;
            default:  `BAD_MUX_SEL;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst_n && ex_mem_write)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (byte_enable[lane])
                    dmem[word_addr][8*lane +: 8] <= store_lanes[8*lane +: 8];
            end
        end
        if (ex_mem_read)
            wb_r_data <= dmem[word_addr];
    end

    // MEM/WB register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_br_en           <= '0;
            wb_mem_byte_enable <= '0;
            wb_pcmux_sel       <= pcmux_pc_plus4;
            wb_regfilemux_sel  <= rf_alu_out;
            wb_load_regfile    <= 1'b0;
            wb_rd              <= '0;
        end
        else
        begin
            wb_br_en           <= ex_br_en;
            wb_mem_byte_enable <= byte_enable;
            wb_pcmux_sel       <= ex_pcmux_sel;
            wb_regfilemux_sel  <= ex_regfilemux_sel;
            wb_load_regfile    <= ex_load_regfile;
            wb_rd              <= ex_rd;
        end
        wb_pc_plus4 <= ex_pc_plus4;
        wb_alu_out  <= ex_alu_out;
        wb_imm      <= ex_imm;
    end

    // Halfword accesses arrive aligned from decode
    assert property (@(posedge clk) disable iff (!rst_n)
        ((ex_mem_read || ex_mem_write) && access_width == mem_half) |-> !ex_alu_out[0])
        else $error("mem_access: misaligned halfword at %h", ex_alu_out);

endmodule

`default_nettype wire

// ==== design/write_back.sv ====
`default_nettype none

`include "rv32i_settings.svh"

module write_back
    import rv32i_types_pkg::*;
    import datapath_mux_pkg::*;
(
    input  rv32i_word       pc_plus4_in,
    input  rv32i_word       alu_in,
    input  rv32i_word       br_en_in,
    input  rv32i_word       u_imm_in,
    input  rv32i_word       r_data_in,
    input  byte_en_t        mem_byte_enable_in,
    input  pcmux_sel_t      pcmux_sel_in,
    input  regfilemux_sel_t regfilemux_sel_in,
    input  logic            load_regfile_in,
    input  rv32i_reg        rd_idx_in,

    // Register file write port
    output logic            load_regfile,
    output rv32i_word       rd_in,
    output rv32i_reg        rd,

    // Fetch redirect
    output rv32i_word       alu_out_to_pc,
    output pcmux_sel_t      pcmux_sel
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    assign load_regfile  = load_regfile_in;
    assign rd            = rd_idx_in;
    assign alu_out_to_pc = alu_in;

    // Not taken falls through to the next sequential PC
    always_comb
    begin
        if (br_en_in[0])
            pcmux_sel = pcmux_sel_in;
        else
            pcmux_sel = pcmux_pc_plus4;
    end

    // Lane picked by the byte enable, lowest lane otherwise
    always_comb
    begin
        case (mem_byte_enable_in)
            4'b0010: load_byte = r_data_in[15:8];
            4'b0100: load_byte = r_data_in[23:16];
            4'b1000: load_byte = r_data_in[31:24];
            default: load_byte = r_data_in[7:0];
        endcase
    end

    always_comb
    begin
        case (mem_byte_enable_in)
            4'b1100: load_half = r_data_in[31:16];
            default: load_half = r_data_in[15:0];
        endcase
    end

    always_comb
    begin
        rd_in = alu_in;
        unique case (regfilemux_sel_in)
            rf_alu_out:  rd_in = alu_in;
            rf_br_en:    rd_in = br_en_in;
            rf_u_imm:    rd_in = u_imm_in;
            rf_lw:       rd_in = r_data_in;
            rf_pc_plus4: rd_in = pc_plus4_in;
            rf_lb:       rd_in = {{24{load_byte[7]}}, load_byte};
            rf_lbu:      rd_in = {{24{1'b0}}, load_byte};
            rf_lh:       rd_in = {{16{load_half[15]}}, load_half};
            rf_lhu:      rd_in = {{16{1'b0}}, load_half};
            default:     `BAD_MUX_SEL;
        endcase
    end

    // The select registered in MEM/WB must be defined for every real write
    always_comb
    begin
        if (load_regfile_in)
        begin
            assert (!$isunknown(regfilemux_sel_in))
                else $error("write_back: unknown regfilemux_sel with load_regfile set");
        end
    end

endmodule

`default_nettype wire

// ==== design/rv32i_backend.sv ====
`default_nettype none

module rv32i_backend
    import rv32i_types_pkg::*;
    import datapath_mux_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  rv32i_word       pc,
    input  rv32i_word       rs1_data,
    input  rv32i_word       rs2_data,
    input  rv32i_word       imm,
    input  alu_ops_t        alu_op,
    input  cmp_ops_t        cmp_op,
    input  alumux1_sel_t    alumux1_sel,
    input  alumux2_sel_t    alumux2_sel,
    input  pcmux_sel_t      pcmux_sel_in,
    input  regfilemux_sel_t regfilemux_sel,
    input  logic            load_regfile_in,
    input  logic            mem_read,
    input  logic            mem_write,
    input  mem_width_t      mem_width,
    input  rv32i_reg        rd_in_idx,

    output logic            load_regfile,
    output rv32i_reg        rd,
    output rv32i_word       rd_in,
    output rv32i_word       alu_out_to_pc,
    output pcmux_sel_t      pcmux_sel
);

    // EX/MEM
    rv32i_word       ex_pc_plus4;
    rv32i_word       ex_alu_out;
    rv32i_word       ex_br_en;
    rv32i_word       ex_store_data;
    rv32i_word       ex_imm;
    pcmux_sel_t      ex_pcmux_sel;
    regfilemux_sel_t ex_regfilemux_sel;
    logic            ex_load_regfile;
    logic            ex_mem_read;
    logic            ex_mem_write;
    mem_width_t      ex_mem_width;
    rv32i_reg        ex_rd;

    // MEM/WB
    rv32i_word       wb_pc_plus4;
    rv32i_word       wb_alu_out;
    rv32i_word       wb_br_en;
    rv32i_word       wb_imm;
    rv32i_word       wb_r_data;
    byte_en_t        wb_mem_byte_enable;
    pcmux_sel_t      wb_pcmux_sel;
    regfilemux_sel_t wb_regfilemux_sel;
    logic            wb_load_regfile;
    rv32i_reg        wb_rd;

    execute i_execute (
        .clk               (clk),
        .rst_n             (rst_n),
        .pc                (pc),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .imm               (imm),
        .alu_op            (alu_op),
        .cmp_op            (cmp_op),
        .alumux1_sel       (alumux1_sel),
        .alumux2_sel       (alumux2_sel),
        .pcmux_sel_in      (pcmux_sel_in),
        .regfilemux_sel    (regfilemux_sel),
        .load_regfile_in   (load_regfile_in),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .mem_width         (mem_width),
        .rd_in_idx         (rd_in_idx),
        .ex_pc_plus4       (ex_pc_plus4),
        .ex_alu_out        (ex_alu_out),
        .ex_br_en          (ex_br_en),
        .ex_store_data     (ex_store_data),
        .ex_imm            (ex_imm),
        .ex_pcmux_sel      (ex_pcmux_sel),
        .ex_regfilemux_sel (ex_regfilemux_sel),
        .ex_load_regfile   (ex_load_regfile),
        .ex_mem_read       (ex_mem_read),
        .ex_mem_write      (ex_mem_write),
        .ex_mem_width      (ex_mem_width),
        .ex_rd             (ex_rd)
    );

    mem_access i_mem_access (
        .clk                (clk),
        .rst_n              (rst_n),
        .ex_pc_plus4        (ex_pc_plus4),
        .ex_alu_out         (ex_alu_out),
        .ex_br_en           (ex_br_en),
        .ex_store_data      (ex_store_data),
        .ex_imm             (ex_imm),
        .ex_pcmux_sel       (ex_pcmux_sel),
        .ex_regfilemux_sel  (ex_regfilemux_sel),
        .ex_load_regfile    (ex_load_regfile),
        .ex_mem_read        (ex_mem_read),
        .ex_mem_write       (ex_mem_write),
        .ex_mem_width       (ex_mem_width),
        .ex_rd              (ex_rd),
        .wb_pc_plus4        (wb_pc_plus4),
        .wb_alu_out         (wb_alu_out),
        .wb_br_en           (wb_br_en),
        .wb_imm             (wb_imm),
        .wb_r_data          (wb_r_data),
        .wb_mem_byte_enable (wb_mem_byte_enable),
        .wb_pcmux_sel       (wb_pcmux_sel),
        .wb_regfilemux_sel  (wb_regfilemux_sel),
        .wb_load_regfile    (wb_load_regfile),
        .wb_rd              (wb_rd)
    );

    write_back i_write_back (
        .pc_plus4_in        (wb_pc_plus4),
        .alu_in             (wb_alu_out),
        .br_en_in           (wb_br_en),
        .u_imm_in           (wb_imm),
        .r_data_in          (wb_r_data),
        .mem_byte_enable_in (wb_mem_byte_enable),
        .pcmux_sel_in       (wb_pcmux_sel),
        .regfilemux_sel_in  (wb_regfilemux_sel),
        .load_regfile_in    (wb_load_regfile),
        .rd_idx_in          (wb_rd),
        .load_regfile       (load_regfile),
        .rd_in              (rd_in),
        .rd                 (rd),
        .alu_out_to_pc      (alu_out_to_pc),
        .pcmux_sel          (pcmux_sel)
    );

endmodule

`default_nettype wire

// ==== test/tb_rv32i_backend.sv ====
`default_nettype none

`include "rv32i_settings.svh"

module tb_rv32i_backend
    import rv32i_types_pkg::*;
    import datapath_mux_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_BITS    = `DMEM_ADDR_BITS;
    localparam int ALU_COUNT   = 200;
    localparam int CMP_COUNT   = 200;
    localparam int MEM_ROUNDS  = 32;
    localparam int JUMP_ROUNDS = 50;
    // Three stores and thirteen loads per memory round
    localparam int SLOT_COUNT  = ALU_COUNT + CMP_COUNT + 16 * MEM_ROUNDS + 4 * JUMP_ROUNDS;
    // Any slot may be followed by a bubble
    localparam int WATCHDOG_NS = (2 * SLOT_COUNT + 64) * 4;

    typedef struct packed {
        logic       load;
        rv32i_reg   rd;
        rv32i_word  data;
        pcmux_sel_t pcmux;
        logic       chk_target;
        rv32i_word  target;
    } expect_t;

    logic            clk             = 1'b0;
    logic            rst_n           = 1'b0;
    rv32i_word       pc              = '0;
    rv32i_word       rs1_data        = '0;
    rv32i_word       rs2_data        = '0;
    rv32i_word       imm             = '0;
    alu_ops_t        alu_op          = alu_add;
    cmp_ops_t        cmp_op          = cmp_beq;
    alumux1_sel_t    alumux1_sel     = alumux1_rs1;
    alumux2_sel_t    alumux2_sel     = alumux2_imm;
    pcmux_sel_t      pcmux_sel_in    = pcmux_pc_plus4;
    regfilemux_sel_t regfilemux_sel  = rf_alu_out;
    logic            load_regfile_in = 1'b0;
    logic            mem_read        = 1'b0;
    logic            mem_write       = 1'b0;
    mem_width_t      mem_width       = mem_word;
    rv32i_reg        rd_in_idx       = '0;

    logic            load_regfile;
    rv32i_reg        rd;
    rv32i_word       rd_in;
    rv32i_word       alu_out_to_pc;
    pcmux_sel_t      pcmux_sel;

    integer  seed     = 32'h48e4;
    int      errors   = 0;
    int      slots    = 0;
    logic    check_en = 1'b0;
    expect_t exp_now  = '0;
    expect_t exp_d1   = '0;
    expect_t exp_d2   = '0;

    rv32i_word shadow [2**MEM_BITS];
    alu_ops_t  alu_list [8] = '{alu_add, alu_sub, alu_sll, alu_srl,
                                alu_sra, alu_xor, alu_or, alu_and};
    cmp_ops_t  branch_list [8] = '{cmp_beq, cmp_bne, cmp_blt, cmp_bge,
                                   cmp_bltu, cmp_bgeu, cmp_beq, cmp_bne};

    rv32i_backend i_rv32i_backend (.*);

    always #2 clk = ~clk;

    // Expectations follow the two pipeline registers
    always @(posedge clk)
    begin
        check_en <= 1'b1;
        exp_d1   <= exp_now;
        exp_d2   <= exp_d1;
    end

    function automatic rv32i_word rand_word();
        return $random(seed);
    endfunction

    function automatic rv32i_word sext12(rv32i_word w);
        return {{20{w[11]}}, w[11:0]};
    endfunction

    function automatic rv32i_word alu_model(alu_ops_t op, rv32i_word a, rv32i_word b);
        logic [4:0] sh;
        rv32i_word  fill;
        sh = b[4:0];
        // Ones in the bits an arithmetic shift brings in
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (op)
            alu_sub: return a - b;
            alu_sll: return a << sh;
            alu_srl: return a >> sh;
            alu_sra: return (a >> sh) | fill;
            alu_xor: return a ^ b;
            alu_or:  return a | b;
            alu_and: return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic cmp_model(cmp_ops_t op, rv32i_word a, rv32i_word b);
        logic lt_u;
        logic lt_s;
        lt_u = a < b;
        // Opposite signs decide the signed order
        lt_s = (a[31] != b[31]) ? a[31] : lt_u;
        case (op)
            cmp_beq:  return a == b;
            cmp_bne:  return a != b;
            cmp_blt:  return lt_s;
            cmp_bge:  return !lt_s;
            cmp_bltu: return lt_u;
            cmp_bgeu: return !lt_u;
            default:  return 1'b1;
        endcase
    endfunction

    function automatic rv32i_word load_model(regfilemux_sel_t sel, rv32i_word word,
                                             logic [1:0] off);
        rv32i_word shifted;
        shifted = word >> {off, 3'b000};
        case (sel)
            rf_lb:   return {{24{shifted[7]}}, shifted[7:0]};
            rf_lbu:  return {24'd0, shifted[7:0]};
            rf_lh:   return {{16{shifted[15]}}, shifted[15:0]};
            rf_lhu:  return {16'd0, shifted[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic report_mismatch(string name, rv32i_word got, rv32i_word want);
        errors++;
        $display("error %0t %s got %h expected %h", $time, name, got, want);
    endtask

    // Bubble controls that the caller overrides in the same step
    task automatic next_slot();
        @(posedge clk);
        alu_op          <= alu_add;
        cmp_op          <= cmp_beq;
        alumux1_sel     <= alumux1_rs1;
        alumux2_sel     <= alumux2_imm;
        pcmux_sel_in    <= pcmux_pc_plus4;
        regfilemux_sel  <= rf_alu_out;
        load_regfile_in <= 1'b0;
        mem_read        <= 1'b0;
        mem_write       <= 1'b0;
        mem_width       <= mem_word;
        exp_now         <= '0;
        slots++;
    endtask

    task automatic maybe_bubble();
        rv32i_word w;
        w = rand_word();
        if (w[1:0] == 2'b00)
            next_slot();
    endtask

    task automatic run_alu_op();
        rv32i_word w;
        rv32i_word a;
        rv32i_word b;
        rv32i_word i;
        alu_ops_t  op;
        expect_t   e;
        w = rand_word();
        a = rand_word();
        b = rand_word();
        i = sext12(rand_word());
        op = alu_list[w[2:0]];
        next_slot();
        rs1_data        <= a;
        rs2_data        <= b;
        imm             <= i;
        alu_op          <= op;
        alumux2_sel     <= w[3] ? alumux2_rs2 : alumux2_imm;
        load_regfile_in <= 1'b1;
        rd_in_idx       <= w[8:4];
        e = '0;
        e.load = 1'b1;
        e.rd   = w[8:4];
        e.data = alu_model(op, a, w[3] ? b : i);
        exp_now <= e;
    endtask

    task automatic run_compare();
        rv32i_word w;
        rv32i_word a;
        rv32i_word b;
        rv32i_word p;
        rv32i_word i;
        cmp_ops_t  op;
        expect_t   e;
        w = rand_word();
        a = rand_word();
        b = w[0] ? a : rand_word();
        p = rand_word();
        p[1:0] = 2'b00;
        i = sext12(rand_word());
        i[0] = 1'b0;
        e = '0;
        next_slot();
        pc       <= p;
        rs1_data <= a;
        rs2_data <= b;
        imm      <= i;
        if (w[3:2] == 2'b00)
        begin
            // slt or sltu
            op = w[1] ? cmp_bltu : cmp_blt;
            cmp_op          <= op;
            regfilemux_sel  <= rf_br_en;
            load_regfile_in <= 1'b1;
            rd_in_idx       <= w[12:8];
            e.load = 1'b1;
            e.rd   = w[12:8];
            e.data = {31'd0, cmp_model(op, a, b)};
        end
        else
        begin
            op = branch_list[w[6:4]];
            cmp_op       <= op;
            alumux1_sel  <= alumux1_pc;
            pcmux_sel_in <= pcmux_alu_out;
            e.pcmux      = cmp_model(op, a, b) ? pcmux_alu_out : pcmux_pc_plus4;
            e.chk_target = 1'b1;
            e.target     = p + i;
        end
        exp_now <= e;
    endtask

    task automatic store_op(mem_width_t width, rv32i_word addr, rv32i_word data);
        rv32i_word             i;
        logic [MEM_BITS-1:0]   idx;
        logic [1:0]            off;
        i = sext12(rand_word());
        idx = addr[MEM_BITS+1:2];
        off = addr[1:0];
        next_slot();
        rs1_data  <= addr - i;
        rs2_data  <= data;
        imm       <= i;
        mem_write <= 1'b1;
        mem_width <= width;
        case (width)
            mem_byte: shadow[idx][{off, 3'b000} +: 8]      = data[7:0];
            mem_half: shadow[idx][{off[1], 4'b0000} +: 16] = data[15:0];
            default:  shadow[idx] = data;
        endcase
    endtask

    task automatic load_op(regfilemux_sel_t sel, rv32i_word addr);
        rv32i_word           w;
        rv32i_word           i;
        logic [MEM_BITS-1:0] idx;
        expect_t             e;
        w = rand_word();
        i = sext12(w);
        idx = addr[MEM_BITS+1:2];
        next_slot();
        rs1_data        <= addr - i;
        imm             <= i;
        mem_read        <= 1'b1;
        regfilemux_sel  <= sel;
        load_regfile_in <= 1'b1;
        rd_in_idx       <= w[20:16];
        e = '0;
        e.load = 1'b1;
        e.rd   = w[20:16];
        e.data = load_model(sel, shadow[idx], addr[1:0]);
        exp_now <= e;
    endtask

    // Whole word first so every lane read back is defined
    task automatic run_mem_round();
        rv32i_word  base;
        rv32i_word  w;
        logic [1:0] off;
        base = rand_word();
        base[1:0] = 2'b00;
        w = rand_word();
        store_op(mem_word, base, rand_word());
        store_op(mem_half, {base[31:2], w[1], 1'b0}, rand_word());
        store_op(mem_byte, {base[31:2], w[3:2]}, rand_word());
        load_op(rf_lw, base);
        for (int k = 0; k < 4; k++)
        begin
            off = 2'(k);
            load_op(rf_lb, {base[31:2], off});
            load_op(rf_lbu, {base[31:2], off});
            if (!off[0])
            begin
                load_op(rf_lh, {base[31:2], off});
                load_op(rf_lhu, {base[31:2], off});
            end
        end
    endtask

    task automatic run_upper_jump();
        rv32i_word w;
        rv32i_word p;
        rv32i_word a;
        expect_t   e;
        // lui
        w = rand_word();
        next_slot();
        imm             <= {w[31:12], 12'h000};
        regfilemux_sel  <= rf_u_imm;
        load_regfile_in <= 1'b1;
        rd_in_idx       <= w[4:0];
        e = '0;
        e.load = 1'b1;
        e.rd   = w[4:0];
        e.data = {w[31:12], 12'h000};
        exp_now <= e;
        maybe_bubble();
        // auipc
        p = rand_word();
        p[1:0] = 2'b00;
        w = rand_word();
        next_slot();
        pc              <= p;
        imm             <= {w[31:12], 12'h000};
        alumux1_sel     <= alumux1_pc;
        load_regfile_in <= 1'b1;
        rd_in_idx       <= w[4:0];
        e.rd   = w[4:0];
        e.data = p + {w[31:12], 12'h000};
        exp_now <= e;
        maybe_bubble();
        // jal with a 21-bit even offset
        p = rand_word();
        p[1:0] = 2'b00;
        w = rand_word();
        next_slot();
        pc              <= p;
        imm             <= {{11{w[20]}}, w[20:1], 1'b0};
        alumux1_sel     <= alumux1_pc;
        cmp_op          <= cmp_always;
        pcmux_sel_in    <= pcmux_alu_out;
        regfilemux_sel  <= rf_pc_plus4;
        load_regfile_in <= 1'b1;
        rd_in_idx       <= w[25:21];
        e.rd         = w[25:21];
        e.data       = p + 32'd4;
        e.pcmux      = pcmux_alu_out;
        e.chk_target = 1'b1;
        e.target     = p + {{11{w[20]}}, w[20:1], 1'b0};
        exp_now <= e;
        maybe_bubble();
        // jalr
        p = rand_word();
        p[1:0] = 2'b00;
        a = rand_word();
        w = rand_word();
        next_slot();
        pc              <= p;
        rs1_data        <= a;
        imm             <= sext12(w);
        cmp_op          <= cmp_always;
        pcmux_sel_in    <= pcmux_alu_mod2;
        regfilemux_sel  <= rf_pc_plus4;
        load_regfile_in <= 1'b1;
        rd_in_idx       <= w[16:12];
        e.rd     = w[16:12];
        e.data   = p + 32'd4;
        e.pcmux  = pcmux_alu_mod2;
        e.target = a + sext12(w);
        exp_now <= e;
        maybe_bubble();
    endtask

    assert property (@(posedge clk) check_en |-> load_regfile == exp_d2.load)
        else report_mismatch("load_regfile", 32'($sampled(load_regfile)),
                             32'($sampled(exp_d2.load)));

    assert property (@(posedge clk) (check_en && exp_d2.load) |-> rd == exp_d2.rd)
        else report_mismatch("rd", 32'($sampled(rd)), 32'($sampled(exp_d2.rd)));

    assert property (@(posedge clk) (check_en && exp_d2.load) |-> rd_in == exp_d2.data)
        else report_mismatch("rd_in", $sampled(rd_in), $sampled(exp_d2.data));

    assert property (@(posedge clk) check_en |-> pcmux_sel == exp_d2.pcmux)
        else report_mismatch("pcmux_sel", 32'($sampled(pcmux_sel)),
                             32'($sampled(exp_d2.pcmux)));

    assert property (@(posedge clk)
        (check_en && exp_d2.chk_target) |-> alu_out_to_pc == exp_d2.target)
        else report_mismatch("alu_out_to_pc", $sampled(alu_out_to_pc),
                             $sampled(exp_d2.target));

    assert property (@(posedge clk)
        (check_en && !rst_n) |-> (!load_regfile && pcmux_sel == pcmux_pc_plus4))
    else
    begin
        errors++;
        $display("register write or redirect requested while reset is held at %0t", $time);
    end

    initial
    begin
        // A register write and a taken jump presented while reset is held
        @(posedge clk);
        cmp_op          <= cmp_always;
        pcmux_sel_in    <= pcmux_alu_out;
        load_regfile_in <= 1'b1;
        repeat (3) @(posedge clk);
        rst_n           <= 1'b1;
        cmp_op          <= cmp_beq;
        pcmux_sel_in    <= pcmux_pc_plus4;
        load_regfile_in <= 1'b0;
        repeat (ALU_COUNT)
        begin
            run_alu_op();
            maybe_bubble();
        end
        repeat (CMP_COUNT)
        begin
            run_compare();
            maybe_bubble();
        end
        repeat (MEM_ROUNDS) run_mem_round();
        repeat (JUMP_ROUNDS) run_upper_jump();
        // Drain the last instruction out of write-back
        repeat (3) next_slot();
        @(posedge clk);
        $display("slots issued: %0d, errors: %0d", slots, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/rv32i_types_pkg.sv
design/datapath_mux_pkg.sv
design/execute.sv
design/mem_access.sv
design/write_back.sv
design/rv32i_backend.sv
test/tb_rv32i_backend.sv

// ==== Makefile ====
VERILATOR    = verilator
TOP          = tb_rv32i_backend
FILELIST     = vlog.f
BUILD_DIR    = obj_dir
LOG          = sim.log
COMMON_FLAGS = --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS   = --lint-only
SIM_FLAGS    = --binary -j 0 --Mdir $(BUILD_DIR)
FAIL_MSG     = Result: FAILED
PASS_MSG     = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
